// File: Makefile
TOP := dataPathTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module dataPath
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary -j 0 -f project.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// File: design/alu.sv
`timescale 1ns/100ps

module alu (
	input isaPkg::aluOp op,
	input logic [busPkg::dataWidth-1:0] y,
	input logic [busPkg::dataWidth-1:0] bus,
	output logic [busPkg::wideWidth-1:0] result
);

	logic [busPkg::dataWidth-1:0] narrow;
	logic [busPkg::wideWidth-1:0] product;
	logic [4:0] shiftCount;

	assign shiftCount = bus[4:0];

	// signed 32x32, full 64-bit product
	assign product = $signed(y) * $signed(bus);

	always_comb
	begin
		case (op)
			isaPkg::aluAdd:
				narrow = y + bus;
			isaPkg::aluSub:
				narrow = y - bus;
			isaPkg::aluAnd:
				narrow = y & bus;
			isaPkg::aluOr:
				narrow = y | bus;
			isaPkg::aluShl:
				narrow = y << shiftCount;
			isaPkg::aluShr:
				narrow = y >> shiftCount;
			// single operand, taken from the bus
			isaPkg::aluNeg:
				narrow = -bus;
			isaPkg::aluNot:
				narrow = ~bus;
			default:
				narrow = bus;
		endcase
	end

	// everything but mul is zero-extended
	always_comb
	begin
		if (op == isaPkg::aluMul)
		begin
			result = product;
		end
		else
		begin
			result = {{(busPkg::wideWidth - busPkg::dataWidth){1'b0}}, narrow};
		end
	end

endmodule

// File: design/busPkg.sv
package busPkg;

	localparam int dataWidth = 32;
	localparam int wideWidth = 2 * dataWidth;
	localparam int regCount = 16;
	localparam int regSelWidth = $clog2(regCount);

	// what drives the shared bus
	typedef enum logic [2:0] {
		srcReg,
		srcImm,
		srcZLow,
		srcZHigh,
		srcHi,
		srcLo
	} busSource;

endpackage

// File: design/controlSequencer.sv
`timescale 1ns/100ps

module controlSequencer (
	input logic clock,
	input logic rstN,
	input logic [busPkg::dataWidth-1:0] ir,
	input logic instrReq,
	output logic instrAck,
	output logic irLoad,
	input logic outAck,
	output logic outReq,
	output logic outLoad,
	output logic gra,
	output logic grb,
	output logic grc,
	output logic rin,
	output logic rout,
	output logic baseOut,
	output logic yIn,
	output logic zIn,
	output logic hiIn,
	output logic loIn,
	output busPkg::busSource source,
	output isaPkg::aluOp op
);

	typedef enum logic [2:0] {
		idle,
		ackWait,
		step1,
		step2,
		step3,
		outHold,
		outRelease
	} stateType;

	stateType state;
	stateType nextState;
	isaPkg::opcode curOp;
	isaPkg::aluOp aluSel;
	isaPkg::opcode irOp;
	logic isImm;
	logic isUnary;
	logic isMul;
	logic isAlu;

	function automatic isaPkg::aluOp decodeAlu(input isaPkg::opcode code);
		isaPkg::aluOp sel;
		case (code)
			isaPkg::opAdd, isaPkg::opAddi:
				sel = isaPkg::aluAdd;
			isaPkg::opSub:
				sel = isaPkg::aluSub;
			isaPkg::opAnd, isaPkg::opAndi:
				sel = isaPkg::aluAnd;
			isaPkg::opOr, isaPkg::opOri:
				sel = isaPkg::aluOr;
			isaPkg::opShl:
				sel = isaPkg::aluShl;
			isaPkg::opShr:
				sel = isaPkg::aluShr;
			isaPkg::opNeg:
				sel = isaPkg::aluNeg;
			isaPkg::opNot:
				sel = isaPkg::aluNot;
			isaPkg::opMul:
				sel = isaPkg::aluMul;
			default:
				sel = isaPkg::aluPass;
		endcase
		return sel;
	endfunction

	assign irOp = isaPkg::opcode'(ir[isaPkg::opMsb:isaPkg::opLsb]);

	// opcode decoded once, as the instruction handshake closes
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= idle;
			curOp <= isaPkg::opAdd;
			aluSel <= isaPkg::aluPass;
		end
		else
		begin
			state <= nextState;
			if (state == ackWait && !instrReq)
			begin
				curOp <= irOp;
				aluSel <= decodeAlu(irOp);
			end
		end
	end

	assign isImm = curOp inside {isaPkg::opAddi, isaPkg::opAndi, isaPkg::opOri};
	assign isUnary = curOp inside {isaPkg::opNeg, isaPkg::opNot};
	assign isMul = (curOp == isaPkg::opMul);
	assign isAlu = (aluSel != isaPkg::aluPass);

	assign instrAck = (state == ackWait);
	assign outReq = (state == outHold);

	always_comb
	begin
		nextState = state;
		irLoad = 1'b0;
		outLoad = 1'b0;
		gra = 1'b0;
		grb = 1'b0;
		grc = 1'b0;
		rin = 1'b0;
		rout = 1'b0;
		baseOut = 1'b0;
		yIn = 1'b0;
		zIn = 1'b0;
		hiIn = 1'b0;
		loIn = 1'b0;
		source = busPkg::srcReg;
		op = isaPkg::aluPass;
		case (state)
			idle:
			begin
				if (instrReq)
				begin
					irLoad = 1'b1;
					nextState = ackWait;
				end
			end
			ackWait:
			begin
				if (!instrReq)
				begin
					nextState = step1;
				end
			end
			step1:
			begin
				if (isAlu)
				begin
					// rb into Y, base rule only for the immediate forms
					grb = 1'b1;
					rout = 1'b1;
					baseOut = isImm;
					yIn = 1'b1;
					nextState = step2;
				end
				else
				begin
					nextState = idle;
					case (curOp)
						isaPkg::opMfhi:
						begin
							source = busPkg::srcHi;
							gra = 1'b1;
							rin = 1'b1;
						end
						isaPkg::opMflo:
						begin
							source = busPkg::srcLo;
							gra = 1'b1;
							rin = 1'b1;
						end
						isaPkg::opOut:
						begin
							gra = 1'b1;
							rout = 1'b1;
							outLoad = 1'b1;
							nextState = outHold;
						end
						// unused opcodes retire as no-ops
						default:
						begin
							nextState = idle;
						end
					endcase
				end
			end
			step2:
			begin
				zIn = 1'b1;
				op = aluSel;
				if (isImm)
				begin
					source = busPkg::srcImm;
				end
				else
				begin
					rout = 1'b1;
					grb = isUnary;
					grc = !isUnary;
				end
				nextState = step3;
			end
			step3:
			begin
				if (isMul)
				begin
					// HI from the bus, LO straight from Z, ra untouched
					source = busPkg::srcZHigh;
					hiIn = 1'b1;
					loIn = 1'b1;
				end
				else
				begin
					source = busPkg::srcZLow;
					gra = 1'b1;
					rin = 1'b1;
				end
				nextState = idle;
			end
			outHold:
			begin
				if (outAck)
				begin
					nextState = outRelease;
				end
			end
			outRelease:
			begin
				if (!outAck)
				begin
					nextState = idle;
				end
			end
			default:
			begin
				nextState = idle;
			end
		endcase
	end

endmodule

// File: design/dataPath.sv
`timescale 1ns/100ps

module dataPath (
	input logic clock,
	input logic rstN,
	input logic instrReq,
	input logic [busPkg::dataWidth-1:0] instrWord,
	output logic instrAck,
	output logic [busPkg::dataWidth-1:0] outData,
	output logic outReq,
	input logic outAck
);

	logic [busPkg::dataWidth-1:0] ir;
	logic [busPkg::dataWidth-1:0] y;
	logic [busPkg::dataWidth-1:0] hi;
	logic [busPkg::dataWidth-1:0] lo;
	logic [busPkg::dataWidth-1:0] bus;
	logic [busPkg::dataWidth-1:0] immExt;
	logic [busPkg::wideWidth-1:0] z;
	logic [busPkg::wideWidth-1:0] aluResult;
	logic irLoad;
	logic outLoad;
	logic gra;
	logic grb;
	logic grc;
	logic rin;
	logic rout;
	logic baseOut;
	logic yIn;
	logic zIn;
	logic hiIn;
	logic loIn;
	busPkg::busSource source;
	isaPkg::aluOp op;

	regBusIf regs ();

	controlSequencer i_controlSequencer (
		.clock(clock),
		.rstN(rstN),
		.ir(ir),
		.instrReq(instrReq),
		.instrAck(instrAck),
		.irLoad(irLoad),
		.outAck(outAck),
		.outReq(outReq),
		.outLoad(outLoad),
		.gra(gra),
		.grb(grb),
		.grc(grc),
		.rin(rin),
		.rout(rout),
		.baseOut(baseOut),
		.yIn(yIn),
		.zIn(zIn),
		.hiIn(hiIn),
		.loIn(loIn),
		.source(source),
		.op(op)
	);

	selectEncode i_selectEncode (
		.ir(ir),
		.gra(gra),
		.grb(grb),
		.grc(grc),
		.rin(rin),
		.rout(rout),
		.regs(regs.controller),
		.immExt(immExt)
	);

	regFile i_regFile (
		.clock(clock),
		.rstN(rstN),
		.regs(regs.registers)
	);

	alu i_alu (
		.op(op),
		.y(y),
		.bus(bus),
		.result(aluResult)
	);

	// registers always load from the bus
	assign regs.writeData = bus;
	assign regs.baseOut = baseOut;

	always_comb
	begin
		case (source)
			busPkg::srcReg:
				bus = regs.readData;
			busPkg::srcImm:
				bus = immExt;
			busPkg::srcZLow:
				bus = z[busPkg::dataWidth-1:0];
			busPkg::srcZHigh:
				bus = z[busPkg::wideWidth-1:busPkg::dataWidth];
			busPkg::srcHi:
				bus = hi;
			busPkg::srcLo:
				bus = lo;
			default:
				bus = '0;
		endcase
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			y <= '0;
			z <= '0;
			hi <= '0;
			lo <= '0;
		end
		else
		begin
			if (yIn)
			begin
				y <= bus;
			end
			if (zIn)
			begin
				z <= aluResult;
			end
			if (hiIn)
			begin
				hi <= bus;
			end
			// mul low half bypasses the bus
			if (loIn)
			begin
				lo <= z[busPkg::dataWidth-1:0];
			end
		end
	end

	// instruction register and out port data
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			ir <= '0;
			outData <= '0;
		end
		else
		begin
			if (irLoad)
			begin
				ir <= instrWord;
			end
			if (outLoad)
			begin
				outData <= bus;
			end
		end
	end

endmodule

// File: design/isaPkg.sv
package isaPkg;

	// instruction word layout
	localparam int opMsb = 31;
	localparam int opLsb = 27;
	localparam int raMsb = 26;
	localparam int raLsb = 23;
	localparam int rbMsb = 22;
	localparam int rbLsb = 19;
	localparam int rcMsb = 18;
	localparam int rcLsb = 15;
	// immediate overlaps rc
	localparam int immMsb = 18;
	localparam int immLsb = 0;
	localparam int immWidth = immMsb - immLsb + 1;

	typedef enum logic [4:0] {
		opAdd  = 5'd0,
		opSub  = 5'd1,
		opAnd  = 5'd2,
		opOr   = 5'd3,
		opShl  = 5'd4,
		opShr  = 5'd5,
		opNeg  = 5'd6,
		opNot  = 5'd7,
		opAddi = 5'd8,
		opAndi = 5'd9,
		opOri  = 5'd10,
		opMul  = 5'd11,
		opMfhi = 5'd12,
		opMflo = 5'd13,
		opOut  = 5'd14
	} opcode;

	typedef enum logic [3:0] {
		aluPass,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluShl,
		aluShr,
		aluNeg,
		aluNot,
		aluMul
	} aluOp;

endpackage

// File: design/regBusIf.sv
`timescale 1ns/100ps

interface regBusIf;

	logic [busPkg::regCount-1:0] writeEnable;
	logic [busPkg::dataWidth-1:0] writeData;
	logic [busPkg::regSelWidth-1:0] readSelect;
	logic baseOut;
	logic [busPkg::dataWidth-1:0] readData;

	// datapath side, shared by the top level and the field decoder
	modport controller (
		output writeEnable,
		output writeData,
		output readSelect,
		output baseOut,
		input readData
	);

	modport registers (
		input writeEnable,
		input writeData,
		input readSelect,
		input baseOut,
		output readData
	);

endinterface

// File: design/regFile.sv
`timescale 1ns/100ps

module regFile (
	input logic clock,
	input logic rstN,
	regBusIf.registers regs
);

	logic [busPkg::dataWidth-1:0] sliceOut [busPkg::regCount];
	logic baseZero;

	for (genvar g = 0; g < busPkg::regCount; g++)
	begin : gSlice
		logic [busPkg::dataWidth-1:0] q;

		always_ff @(posedge clock or negedge rstN)
		begin
			if (!rstN)
			begin
				q <= '0;
			end
			else if (regs.writeEnable[g])
			begin
				q <= regs.writeData;
			end
		end

		assign sliceOut[g] = q;
	end

	// base address rule, R0 reads as zero under baseOut
	// R0 itself still holds whatever was written to it
	assign baseZero = regs.baseOut && (regs.readSelect == '0);

	assign regs.readData = baseZero ? '0 : sliceOut[regs.readSelect];

endmodule

// File: design/selectEncode.sv
`timescale 1ns/100ps

module selectEncode (
	input logic [busPkg::dataWidth-1:0] ir,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rin,
	input logic rout,
	regBusIf.controller regs,
	output logic [busPkg::dataWidth-1:0] immExt
);

	logic [busPkg::regSelWidth-1:0] field;

	// one field at a time, ra has priority
	always_comb
	begin
		if (gra)
		begin
			field = ir[isaPkg::raMsb:isaPkg::raLsb];
		end
		else if (grb)
		begin
			field = ir[isaPkg::rbMsb:isaPkg::rbLsb];
		end
		else if (grc)
		begin
			field = ir[isaPkg::rcMsb:isaPkg::rcLsb];
		end
		else
		begin
			field = '0;
		end
	end

	// one-hot write enable
	assign regs.writeEnable = rin ? (busPkg::regCount'(1) << field) : '0;
	assign regs.readSelect = rout ? field : '0;

	assign immExt = {
		{(busPkg::dataWidth - isaPkg::immWidth){ir[isaPkg::immMsb]}},
		ir[isaPkg::immMsb:isaPkg::immLsb]
	};

endmodule

// File: project.f
design/busPkg.sv
design/isaPkg.sv
design/regBusIf.sv
design/selectEncode.sv
design/regFile.sv
design/alu.sv
design/controlSequencer.sv
design/dataPath.sv
verif/dataPathTb.sv

// File: verif/dataPathTb.sv
`timescale 1ns/100ps

module dataPathTb;

	localparam int clockPeriod = 20;
	localparam int resetCycles = 5;
	localparam int randomCount = 400;
	localparam int directedCount = 33;
	localparam int instrTotal = randomCount + directedCount;
	localparam int cyclesPerInstr = 40;

	logic clock;
	logic rstN;
	logic instrReq;
	logic [31:0] instrWord;
	logic instrAck;
	logic [31:0] outData;
	logic outReq;
	logic outAck;

	// reference state of the processor
	logic [31:0] model [16];
	logic [31:0] modelHi;
	logic [31:0] modelLo;

	logic [31:0] lfsr;
	int outsIssued;
	int outsSeen;

	// handshake monitor history
	logic prevInstrReq;
	logic prevInstrAck;
	logic prevOutReq;
	logic prevOutAck;
	logic [31:0] prevOutData;

	dataPath i_dataPath (
		.clock(clock),
		.rstN(rstN),
		.instrReq(instrReq),
		.instrWord(instrWord),
		.instrAck(instrAck),
		.outData(outData),
		.outReq(outReq),
		.outAck(outAck)
	);

	initial
	begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	task automatic reportFailure(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1);
	endtask

	// galois form, taps 32 31 29 1, one step per bit
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD0000001) : (lfsr >> 1);
		end
		return bits;
	endfunction

	function automatic int randomDelay();
		return int'(randomBits(3) % 6);
	endfunction

	function automatic logic [31:0] regWord(input isaPkg::opcode code, input logic [3:0] ra,
			input logic [3:0] rb, input logic [3:0] rc);
		return {code, ra, rb, rc, 15'b0};
	endfunction

	function automatic logic [31:0] immWord(input isaPkg::opcode code, input logic [3:0] ra,
			input logic [3:0] rb, input logic [18:0] imm);
		return {code, ra, rb, imm};
	endfunction

	function automatic isaPkg::opcode randomOpcode();
		isaPkg::opcode code;
		case (randomBits(4) % 14)
			0: code = isaPkg::opAdd;
			1: code = isaPkg::opSub;
			2: code = isaPkg::opAnd;
			3: code = isaPkg::opOr;
			4: code = isaPkg::opShl;
			5: code = isaPkg::opShr;
			6: code = isaPkg::opNeg;
			7: code = isaPkg::opNot;
			8: code = isaPkg::opAddi;
			9: code = isaPkg::opAndi;
			10: code = isaPkg::opOri;
			11: code = isaPkg::opMul;
			12: code = isaPkg::opMfhi;
			default: code = isaPkg::opMflo;
		endcase
		return code;
	endfunction

	// instruction semantics, field by field
	task automatic applyModel(input logic [31:0] word);
		logic [4:0] code;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		logic [31:0] imm;
		logic [31:0] bVal;
		logic [31:0] cVal;
		logic [31:0] baseVal;
		logic [63:0] product;
		code = word[31:27];
		ra = word[26:23];
		rb = word[22:19];
		rc = word[18:15];
		imm = {{13{word[18]}}, word[18:0]};
		bVal = model[rb];
		cVal = model[rc];
		// immediates see R0 as a zero base
		baseVal = (rb == 4'd0) ? 32'h0 : model[rb];
		case (code)
			isaPkg::opAdd: model[ra] = bVal + cVal;
			isaPkg::opSub: model[ra] = bVal - cVal;
			isaPkg::opAnd: model[ra] = bVal & cVal;
			isaPkg::opOr: model[ra] = bVal | cVal;
			isaPkg::opShl: model[ra] = bVal << cVal[4:0];
			isaPkg::opShr: model[ra] = bVal >> cVal[4:0];
			isaPkg::opNeg: model[ra] = ~bVal + 32'd1;
			isaPkg::opNot: model[ra] = ~bVal;
			isaPkg::opAddi: model[ra] = baseVal + imm;
			isaPkg::opAndi: model[ra] = baseVal & imm;
			isaPkg::opOri: model[ra] = baseVal | imm;
			isaPkg::opMul:
			begin
				// low 64 bits of the extended product equal the signed product
				product = {{32{bVal[31]}}, bVal} * {{32{cVal[31]}}, cVal};
				modelHi = product[63:32];
				modelLo = product[31:0];
			end
			isaPkg::opMfhi: model[ra] = modelHi;
			isaPkg::opMflo: model[ra] = modelLo;
			default:
			begin
				// out leaves the state alone
			end
		endcase
	endtask

	task automatic waitCycles(input int count);
		repeat (count) @(negedge clock);
	endtask

	// one instruction through both handshakes, caller sits on a falling edge
	task automatic runInstr(input logic [31:0] word);
		logic [31:0] expected;
		logic isOut;
		isOut = (word[31:27] == isaPkg::opOut);
		expected = model[word[26:23]];
		applyModel(word);
		if (isOut)
		begin
			outsIssued++;
		end
		waitCycles(randomDelay());
		instrWord = word;
		instrReq = 1'b1;
		do @(negedge clock); while (!instrAck);
		waitCycles(randomDelay());
		instrReq = 1'b0;
		do @(negedge clock); while (instrAck);
		if (isOut)
		begin
			do @(negedge clock); while (!outReq);
			assert (outData === expected)
			else reportFailure($sformatf("Mismatch outData expected %h actual %h",
				expected, outData));
			waitCycles(randomDelay());
			outAck = 1'b1;
			do @(negedge clock); while (outReq);
			waitCycles(randomDelay());
			outAck = 1'b0;
		end
	endtask

	always @(posedge clock)
	begin
		if (rstN)
		begin
			// ack rose on the previous edge, so req must have been high there
			if (instrAck && !prevInstrAck)
			begin
				assert (prevInstrReq)
				else reportFailure("instrAck rose while instrReq was low");
			end
			if (!instrAck && prevInstrAck)
			begin
				assert (!prevInstrReq)
				else reportFailure("instrAck fell before instrReq was released");
			end
			if (prevOutReq && !prevOutAck)
			begin
				assert (outReq)
				else reportFailure("outReq fell before outAck rose");
				assert (outData === prevOutData)
				else reportFailure("outData changed while waiting for outAck");
			end
			if (outReq && !prevOutReq)
			begin
				assert (outsSeen < outsIssued)
				else reportFailure("outReq rose without a pending out instruction");
				outsSeen++;
			end
		end
		prevInstrReq = instrReq;
		prevInstrAck = instrAck;
		prevOutReq = outReq;
		prevOutAck = outAck;
		prevOutData = outData;
	end

	initial
	begin
		repeat (resetCycles + instrTotal * cyclesPerInstr) @(posedge clock);
		reportFailure("timeout, the handshakes stopped making progress");
	end

	initial
	begin
		rstN = 1'b0;
		instrReq = 1'b0;
		instrWord = '0;
		outAck = 1'b0;
		lfsr = 32'h820d4b51;
		outsIssued = 0;
		outsSeen = 0;
		prevInstrReq = 1'b0;
		prevInstrAck = 1'b0;
		prevOutReq = 1'b0;
		prevOutAck = 1'b0;
		prevOutData = '0;
		modelHi = '0;
		modelLo = '0;
		for (int r = 0; r < 16; r++)
		begin
			model[r] = '0;
		end
		repeat (resetCycles) @(negedge clock);
		rstN = 1'b1;

		assert (instrAck === 1'b0)
		else reportFailure("instrAck is not low after reset");
		assert (outReq === 1'b0)
		else reportFailure("outReq is not low after reset");
		for (int r = 0; r < 16; r++)
		begin
			runInstr(regWord(isaPkg::opOut, 4'(r), 4'd0, 4'd0));
		end

		// R0 written, then used as a zero base
		runInstr(immWord(isaPkg::opOri, 4'd0, 4'd0, 19'h12345));
		runInstr(immWord(isaPkg::opAddi, 4'd5, 4'd0, 19'h7FFF0));
		runInstr(immWord(isaPkg::opAndi, 4'd6, 4'd0, 19'h7FFFF));
		runInstr(regWord(isaPkg::opAdd, 4'd7, 4'd0, 4'd0));
		runInstr(regWord(isaPkg::opOut, 4'd5, 4'd0, 4'd0));
		runInstr(regWord(isaPkg::opOut, 4'd6, 4'd0, 4'd0));
		runInstr(regWord(isaPkg::opOut, 4'd7, 4'd0, 4'd0));
		runInstr(regWord(isaPkg::opOut, 4'd0, 4'd0, 4'd0));

		// negative times positive through HI and LO
		runInstr(immWord(isaPkg::opAddi, 4'd1, 4'd0, 19'h7FFFB));
		runInstr(immWord(isaPkg::opOri, 4'd2, 4'd0, 19'h3FFFF));
		runInstr(immWord(isaPkg::opAddi, 4'd3, 4'd0, 19'd12));
		runInstr(regWord(isaPkg::opShl, 4'd2, 4'd2, 4'd3));
		runInstr(regWord(isaPkg::opMul, 4'd0, 4'd1, 4'd2));
		runInstr(regWord(isaPkg::opMfhi, 4'd4, 4'd0, 4'd0));
		runInstr(regWord(isaPkg::opMflo, 4'd8, 4'd0, 4'd0));
		runInstr(regWord(isaPkg::opOut, 4'd4, 4'd0, 4'd0));
		runInstr(regWord(isaPkg::opOut, 4'd8, 4'd0, 4'd0));

		// random mix, every fourth one an out
		for (int n = 0; n < randomCount; n++)
		begin
			if (n % 4 == 3)
			begin
				runInstr({isaPkg::opOut, 27'(randomBits(27))});
			end
			else
			begin
				runInstr({randomOpcode(), 27'(randomBits(27))});
			end
		end
		waitCycles(2);

		$display("** PASS **");
		$finish;
	end

endmodule
